// File: source/net_proto_pkg.sv
`default_nettype none

package net_proto_pkg;

    // ******************************
    // field types
    // ******************************
    typedef logic [7:0]  byte_t;    // one gmii byte
    typedef logic [31:0] word_t;    // payload / header word
    typedef logic [15:0] len_t;     // byte counts, length fields
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [15:0] port_t;

    // ******************************
    // ethernet
    // ******************************
    localparam byte_t       PREAMBLE_BYTE = 8'h55;
    localparam byte_t       SFD_BYTE      = 8'hd5;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam len_t        ETH_HDR_BYTES = 16'd14;   // two macs + ethertype

    // ip, udp and the timestamp word behind them
    localparam byte_t IP_PROTO_UDP  = 8'd17;
    localparam len_t  IP_HDR_BYTES  = 16'd20;
    localparam len_t  UDP_HDR_BYTES = 16'd8;
    localparam len_t  STAMP_BYTES   = 16'd4;

    // ip header start through end of timestamp
    localparam len_t IP_UDP_BYTES = IP_HDR_BYTES + UDP_HDR_BYTES + STAMP_BYTES;

    // 46 byte minimum less ip, udp and stamp
    localparam len_t MIN_DATA_BYTES = 16'd14;

endpackage

`default_nettype wire

// File: source/tx_ctrl_pkg.sv
`default_nettype none

package tx_ctrl_pkg;

    // ******************************
    // frame phases, in send order
    // ******************************
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_CSUM,    // ipv4 header checksum
        PH_PRE,     // preamble + sfd
        PH_ETH,
        PH_IP,      // ip header, udp header, stamp
        PH_PAY,     // payload then zero pad
        PH_FCS
    } phase_t;

    typedef logic [15:0] idx_t;    // byte index inside a phase

    localparam idx_t CSUM_CYCLES = 16'd4;   // add, fold, fold, invert
    localparam idx_t PRE_BYTES   = 16'd8;
    localparam idx_t FCS_BYTES   = 16'd4;

endpackage

`default_nettype wire

// File: source/frame_sequencer.sv
`default_nettype none

module frame_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_valid,
    input  logic                csum_done,
    input  net_proto_pkg::len_t pay_len,
    output logic                start_ready,
    output logic                frame_start,
    output logic                frame_end,
    output logic                tx_done,
    output tx_ctrl_pkg::phase_t phase,
    output tx_ctrl_pkg::idx_t   idx
);
    import net_proto_pkg::*;
    import tx_ctrl_pkg::*;

    logic   launch;       // latch cycle before the checksum
    len_t   pad_len;
    idx_t   last_idx;
    phase_t next_phase;
    logic   last;

    assign pad_len = (pay_len > MIN_DATA_BYTES) ? pay_len : MIN_DATA_BYTES;

    // stays low until tx_done, so one frame in flight
    assign start_ready = (phase == PH_IDLE) && !launch && !frame_end;
    assign frame_start = start_valid && start_ready;

    // ******************************
    // phase length and successor
    // ******************************
    always_comb begin
        case (phase)
            PH_PRE: begin
                last_idx   = PRE_BYTES - 16'd1;
                next_phase = PH_ETH;
            end
            PH_ETH: begin
                last_idx   = ETH_HDR_BYTES - 16'd1;
                next_phase = PH_IP;
            end
            PH_IP: begin
                last_idx   = IP_UDP_BYTES - 16'd1;
                next_phase = PH_PAY;
            end
            PH_PAY: begin
                last_idx   = pad_len - 16'd1;   // short payloads get padded
                next_phase = PH_FCS;
            end
            default: begin
                last_idx   = FCS_BYTES - 16'd1;
                next_phase = PH_IDLE;
            end
        endcase
    end

    assign last = (idx == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            idx       <= '0;
            launch    <= 1'b0;
            frame_end <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            launch    <= frame_start;
            frame_end <= (phase == PH_FCS) && last;   // lines up with last gmii byte
            tx_done   <= frame_end;
            case (phase)
                PH_IDLE: begin
                    idx <= '0;
                    if (launch)
                        phase <= PH_CSUM;
                end
                PH_CSUM: begin
                    if (csum_done) begin
                        phase <= PH_PRE;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
                default: begin
                    if (last) begin
                        phase <= next_phase;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/frame_header.sv
`default_nettype none

module frame_header #(
    parameter net_proto_pkg::port_t SRC_PORT     = 16'd1234,
    parameter net_proto_pkg::port_t DST_PORT_MIN = 16'd1234,
    parameter net_proto_pkg::port_t DST_PORT_MAX = 16'd1239
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_start,
    input  logic                  frame_end,
    input  net_proto_pkg::len_t   byte_num,
    input  net_proto_pkg::mac_t   des_mac,
    input  net_proto_pkg::ipv4_t  des_ip,
    input  net_proto_pkg::mac_t   board_mac,
    input  net_proto_pkg::ipv4_t  board_ip,
    input  tx_ctrl_pkg::phase_t   phase,
    input  tx_ctrl_pkg::idx_t     idx,
    output net_proto_pkg::len_t   pay_len,
    output logic                  csum_done,
    output net_proto_pkg::byte_t  hdr_byte
);
    import net_proto_pkg::*;
    import tx_ctrl_pkg::*;

    localparam logic [15:0] VER_TOS   = 16'h4500;   // v4, ihl 5, tos 0
    localparam logic [15:0] FLAGS_DF  = 16'h4000;
    localparam logic [15:0] TTL_PROTO = {8'h40, IP_PROTO_UDP};
    localparam len_t        UDP_ADD   = UDP_HDR_BYTES + STAMP_BYTES;

    mac_t         des_mac_q;
    mac_t         board_mac_q;
    ipv4_t        des_ip_q;
    ipv4_t        board_ip_q;
    len_t         ip_len;
    len_t         udp_len;
    logic [15:0]  ip_id;
    port_t        dst_port;
    word_t        frame_cnt;     // timestamp, frames sent
    logic [31:0]  hw_sum;
    logic [31:0]  csum_acc;
    logic [15:0]  ip_csum;
    logic [111:0] eth_vec;
    logic [255:0] ip_vec;
    logic [6:0]   eth_bit;
    logic [7:0]   ip_bit;

    always_ff @(posedge clk) begin
        if (frame_start) begin
            des_mac_q   <= des_mac;
            board_mac_q <= board_mac;
            des_ip_q    <= des_ip;
            board_ip_q  <= board_ip;
            ip_len      <= byte_num + IP_UDP_BYTES;
            udp_len     <= byte_num + UDP_ADD;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pay_len   <= '0;
            ip_id     <= '0;
            dst_port  <= DST_PORT_MIN;
            frame_cnt <= '0;
        end else begin
            if (frame_start)
                pay_len <= byte_num;
            if (frame_end) begin
                ip_id     <= ip_id + 16'd1;
                dst_port  <= (dst_port >= DST_PORT_MAX) ? DST_PORT_MIN : dst_port + 16'd1;
                frame_cnt <= frame_cnt + 32'd1;
            end
        end
    end

    // ******************************
    // ipv4 header checksum
    // ******************************
    assign hw_sum = 32'(VER_TOS) + 32'(ip_len) + 32'(ip_id) + 32'(FLAGS_DF)
                  + 32'(TTL_PROTO) + 32'(board_ip_q[31:16]) + 32'(board_ip_q[15:0])
                  + 32'(des_ip_q[31:16]) + 32'(des_ip_q[15:0]);

    always_ff @(posedge clk) begin
        if (phase == PH_CSUM) begin
            case (idx[1:0])
                2'd0:       csum_acc <= hw_sum;
                2'd1, 2'd2: csum_acc <= 32'(csum_acc[31:16]) + 32'(csum_acc[15:0]);
                default:    ip_csum  <= ~csum_acc[15:0];
            endcase
        end
    end

    assign csum_done = (phase == PH_CSUM) && (idx == CSUM_CYCLES - 16'd1);

    // header images, first byte at the top
    assign eth_vec = {des_mac_q, board_mac_q, ETH_TYPE_IPV4};
    assign ip_vec  = {VER_TOS, ip_len, ip_id, FLAGS_DF, TTL_PROTO, ip_csum,
                      board_ip_q, des_ip_q, SRC_PORT, dst_port, udp_len, 16'h0000,
                      frame_cnt};
    assign eth_bit = 7'(8 * (ETH_HDR_BYTES - 16'd1 - idx));
    assign ip_bit  = 8'(8 * (IP_UDP_BYTES - 16'd1 - idx));

    always_comb begin
        case (phase)
            PH_ETH:  hdr_byte = eth_vec[eth_bit +: 8];
            PH_IP:   hdr_byte = ip_vec[ip_bit +: 8];
            default: hdr_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: source/crc32_d8.sv
`default_nettype none

module crc32_d8 (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 crc_clr,
    input  logic                 crc_en,
    input  net_proto_pkg::byte_t crc_byte,
    output net_proto_pkg::word_t crc_state
);
    import net_proto_pkg::*;

    localparam word_t POLY = 32'h04C1_1DB7;

    word_t crc_next;

    // msb-first register, byte fed lsb first
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[31] ^ crc_byte[i])
                crc_next = {crc_next[30:0], 1'b0} ^ POLY;
            else
                crc_next = {crc_next[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            crc_state <= '1;
        else if (crc_clr)
            crc_state <= '1;        // ready for next frame
        else if (crc_en)
            crc_state <= crc_next;
    end

endmodule

`default_nettype wire

// File: source/gmii_byte_mux.sv
`default_nettype none

module gmii_byte_mux (
    input  logic                 clk,
    input  logic                 rst_n,
    input  tx_ctrl_pkg::phase_t  phase,
    input  tx_ctrl_pkg::idx_t    idx,
    input  net_proto_pkg::len_t  pay_len,
    input  net_proto_pkg::byte_t hdr_byte,
    input  net_proto_pkg::word_t crc_state,
    input  net_proto_pkg::word_t data_word,
    output logic                 data_take,
    output logic                 crc_en,
    output logic                 crc_clr,
    output net_proto_pkg::byte_t crc_byte,
    output logic                 gmii_tx_en,
    output net_proto_pkg::byte_t gmii_txd
);
    import net_proto_pkg::*;
    import tx_ctrl_pkg::*;

    logic  in_payload;     // real payload byte, not pad
    logic  in_frame;
    byte_t pay_byte;
    word_t fcs_word;
    byte_t next_byte;

    assign in_payload = (phase == PH_PAY) && (idx < pay_len);
    assign in_frame   = (phase != PH_IDLE) && (phase != PH_CSUM);

    // msb first within a word
    assign pay_byte = in_payload ? data_word[{~idx[1:0], 3'b000} +: 8] : 8'h00;

    // last byte of a word, or the tail of a partial word
    assign data_take = in_payload && ((idx[1:0] == 2'd3) || (idx == pay_len - 16'd1));

    // ******************************
    // fcs = reversed complement
    // ******************************
    assign fcs_word = {<<{~crc_state}};

    always_comb begin
        case (phase)
            PH_PRE:        next_byte = (idx == PRE_BYTES - 16'd1) ? SFD_BYTE : PREAMBLE_BYTE;
            PH_ETH, PH_IP: next_byte = hdr_byte;
            PH_PAY:        next_byte = pay_byte;
            PH_FCS:        next_byte = fcs_word[{idx[1:0], 3'b000} +: 8];  // lsb first
            default:       next_byte = 8'h00;
        endcase
    end

    // crc covers headers, payload and pad
    assign crc_en   = (phase == PH_ETH) || (phase == PH_IP) || (phase == PH_PAY);
    assign crc_byte = next_byte;
    assign crc_clr  = (phase == PH_FCS) && (idx == FCS_BYTES - 16'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
        end else begin
            gmii_tx_en <= in_frame;
            gmii_txd   <= next_byte;
        end
    end

endmodule

`default_nettype wire

// File: source/udp_gmii_tx.sv
`default_nettype none

module udp_gmii_tx #(
    parameter net_proto_pkg::port_t SRC_PORT     = 16'd1234,
    parameter net_proto_pkg::port_t DST_PORT_MIN = 16'd1234,
    parameter net_proto_pkg::port_t DST_PORT_MAX = 16'd1239
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_valid,
    input  net_proto_pkg::len_t   byte_num,
    input  net_proto_pkg::mac_t   des_mac,
    input  net_proto_pkg::ipv4_t  des_ip,
    input  net_proto_pkg::mac_t   board_mac,
    input  net_proto_pkg::ipv4_t  board_ip,
    input  net_proto_pkg::word_t  data_word,
    output logic                  start_ready,
    output logic                  data_take,
    output logic                  gmii_tx_en,
    output net_proto_pkg::byte_t  gmii_txd,
    output logic                  tx_done
);
    import net_proto_pkg::*;
    import tx_ctrl_pkg::*;

    phase_t phase;
    idx_t   idx;
    logic   frame_start;
    logic   frame_end;
    logic   csum_done;
    len_t   pay_len;
    byte_t  hdr_byte;
    logic   crc_en;
    logic   crc_clr;
    byte_t  crc_byte;
    word_t  crc_state;

    frame_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start_valid(start_valid), .csum_done(csum_done),
        .pay_len(pay_len), .start_ready(start_ready), .frame_start(frame_start),
        .frame_end(frame_end), .tx_done(tx_done), .phase(phase), .idx(idx)
    );

    frame_header #(
        .SRC_PORT(SRC_PORT), .DST_PORT_MIN(DST_PORT_MIN), .DST_PORT_MAX(DST_PORT_MAX)
    ) u_hdr (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start), .frame_end(frame_end),
        .byte_num(byte_num), .des_mac(des_mac), .des_ip(des_ip), .board_mac(board_mac),
        .board_ip(board_ip), .phase(phase), .idx(idx), .pay_len(pay_len),
        .csum_done(csum_done), .hdr_byte(hdr_byte)
    );

    crc32_d8 u_crc (
        .clk(clk), .rst_n(rst_n), .crc_clr(crc_clr), .crc_en(crc_en),
        .crc_byte(crc_byte), .crc_state(crc_state)
    );

    gmii_byte_mux u_mux (
        .clk(clk), .rst_n(rst_n), .phase(phase), .idx(idx), .pay_len(pay_len),
        .hdr_byte(hdr_byte), .crc_state(crc_state), .data_word(data_word),
        .data_take(data_take), .crc_en(crc_en), .crc_clr(crc_clr), .crc_byte(crc_byte),
        .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd)
    );

endmodule

`default_nettype wire

// File: verif/udp_gmii_tx_asserts.sv
`default_nettype none

module udp_gmii_tx_asserts (
    input logic clk,
    input logic rst_n,
    input logic start_ready,
    input logic gmii_tx_en,
    input logic tx_done,
    input logic data_take
);
    timeunit 1ns;
    timeprecision 100ps;

    // ******************************
    // handshake and framing
    // ******************************
    ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        gmii_tx_en |-> !start_ready)
        else $error("start_ready high while a frame is on gmii");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else $error("tx_done held longer than one cycle");

    // payload is only pulled mid frame
    take_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        data_take |-> gmii_tx_en)
        else $error("data_take outside a frame");

endmodule

bind udp_gmii_tx udp_gmii_tx_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .start_ready(start_ready), .gmii_tx_en(gmii_tx_en),
    .tx_done(tx_done), .data_take(data_take)
);

`default_nettype wire

// File: verif/tb_udp_gmii_tx.sv
`default_nettype none

module tb_udp_gmii_tx;
    timeunit 1ns;
    timeprecision 100ps;
    import net_proto_pkg::*;

    localparam int   N_FRAMES    = 20;
    localparam int   CYCLE_LIMIT = N_FRAMES * 120 + 200;
    localparam int   MIN_BODY    = 14 + 20 + 8 + 4 + 14;   // eth through padded payload
    localparam int   DST_MIN     = 1234;
    localparam int   DST_MAX     = 1239;
    localparam len_t FIRST_EN    = 16'd7;   // rises 6 edges after accept and is seen one later

    logic  clk;
    logic  rst_n;
    logic  start_valid;
    len_t  byte_num;
    mac_t  des_mac;
    ipv4_t des_ip;
    mac_t  board_mac;
    ipv4_t board_ip;
    word_t data_word;
    logic  start_ready;
    logic  data_take;
    logic  gmii_tx_en;
    byte_t gmii_txd;
    logic  tx_done;

    integer seed = 72;
    int     errors = 0;
    int     cycles = 0;
    int     issued = 0;
    int     done_cnt = 0;
    int     checked = 0;
    int     gap = 0;
    int     run_len = 0;
    int     takes = 0;
    int     accept_cyc = 0;
    logic   prev_en = 1'b0;
    byte_t  exp_q[$];      // expected gmii bytes of all frames
    byte_t  body_q[$];     // crc-covered bytes of the frame being built
    word_t  word_q[$];     // payload words still to be taken
    len_t   len_q[$];
    len_t   take_q[$];

    udp_gmii_tx #(
        .SRC_PORT(16'd1234), .DST_PORT_MIN(16'(DST_MIN)), .DST_PORT_MAX(16'(DST_MAX))
    ) uut (
        .clk(clk), .rst_n(rst_n), .start_valid(start_valid), .byte_num(byte_num),
        .des_mac(des_mac), .des_ip(des_ip), .board_mac(board_mac), .board_ip(board_ip),
        .data_word(data_word), .start_ready(start_ready), .data_take(data_take),
        .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd), .tx_done(tx_done)
    );

    always #2 clk = ~clk;

    // ******************************
    // compare tasks
    // ******************************
    task automatic byte_matches(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic len_matches(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic bit_matches(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ******************************
    // reference frame model
    // ******************************
    task automatic push_field(input logic [63:0] val, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--)
            body_q.push_back(val[8 * i +: 8]);   // network order
    endtask

    function automatic logic [15:0] ip_checksum(input len_t total, input logic [15:0] id,
                                                input ipv4_t src, input ipv4_t dst);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(total) + 32'(id) + 32'h4000 + 32'h4011
            + 32'(src[31:16]) + 32'(src[15:0]) + 32'(dst[31:16]) + 32'(dst[15:0]);
        while (sum[31:16] != 16'h0)
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        return ~sum[15:0];
    endfunction

    // standard reflected ethernet crc
    function automatic word_t crc_of_body();
        word_t crc;
        crc = 32'hffff_ffff;
        foreach (body_q[i]) begin
            crc = crc ^ 32'(body_q[i]);
            for (int b = 0; b < 8; b++)
                crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
        end
        return ~crc;
    endfunction

    task automatic issue_command();
        int    n;
        int    k;
        len_t  total;
        len_t  udp_len;
        mac_t  dmac;
        mac_t  smac;
        ipv4_t dip;
        ipv4_t sip;
        word_t w;
        word_t crc;
        n    = 1 + int'($unsigned($random(seed)) % 40);
        k    = issued;                      // id, port step and stamp all follow k
        dmac = {16'($random(seed)), 32'($random(seed))};
        smac = {16'($random(seed)), 32'($random(seed))};
        dip  = $random(seed);
        sip  = $random(seed);
        total   = len_t'(n + 32);
        udp_len = len_t'(n + 12);
        body_q.delete();
        push_field(64'(dmac), 6);
        push_field(64'(smac), 6);
        push_field(64'(ETH_TYPE_IPV4), 2);
        push_field({16'h4500, total, 16'(k), 16'h4000}, 8);
        push_field({8'h40, 8'd17, ip_checksum(total, 16'(k), sip, dip), sip}, 8);
        push_field(64'(dip), 4);
        push_field({16'd1234, 16'(DST_MIN + k % (DST_MAX - DST_MIN + 1)), udp_len, 16'h0}, 8);
        push_field(64'(k), 4);
        for (int i = 0; i < (n + 3) / 4; i++) begin
            w = $random(seed);
            word_q.push_back(w);
            for (int b = 0; b < 4; b++)
                if (4 * i + b < n)
                    body_q.push_back(w[31 - 8 * b -: 8]);
        end
        while (body_q.size() < MIN_BODY)
            body_q.push_back(8'h00);        // pad
        crc = crc_of_body();
        repeat (7)
            exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        foreach (body_q[i])
            exp_q.push_back(body_q[i]);
        for (int i = 0; i < 4; i++)
            exp_q.push_back(crc[8 * i +: 8]);
        len_q.push_back(len_t'(body_q.size() + 12));
        take_q.push_back(len_t'((n + 3) / 4));
        start_valid <= 1'b1;
        byte_num    <= len_t'(n);
        des_mac     <= dmac;
        board_mac   <= smac;
        des_ip      <= dip;
        board_ip    <= sip;
        issued++;
    endtask

    // command and payload source
    always @(posedge clk) begin
        if (rst_n) begin
            if (data_take && word_q.size() > 0)
                void'(word_q.pop_front());
            if (start_valid && start_ready) begin
                start_valid <= 1'b0;
                gap = int'($unsigned($random(seed)) % 8);
            end else if (!start_valid && issued < N_FRAMES) begin
                if (gap > 0)
                    gap--;
                else
                    issue_command();
            end
            data_word <= (word_q.size() > 0) ? word_q[0] : 32'h0;
        end
    end

    // ******************************
    // gmii monitor and timeout
    // ******************************
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d frames done",
                     cycles, done_cnt, N_FRAMES);
            $display("Simulation finished: FAIL");
            $finish;
        end else if (rst_n) begin
            if (start_valid && start_ready)
                accept_cyc = cycles;
            if (gmii_tx_en) begin
                if (!prev_en)
                    len_matches("accept to gmii_tx_en", len_t'(cycles - accept_cyc), FIRST_EN);
                run_len++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("gmii_tx_en high at %0t with no frame expected", $time);
                end else begin
                    byte_matches("gmii_txd", gmii_txd, exp_q.pop_front());
                    checked++;
                end
            end else if (prev_en) begin
                len_matches("gmii_tx_en length", len_t'(run_len), len_q.pop_front());
                run_len = 0;
            end
            if (data_take)
                takes++;
            if (tx_done) begin
                bit_matches("gmii_tx_en before tx_done", prev_en, 1'b1);
                bit_matches("gmii_tx_en at tx_done", gmii_tx_en, 1'b0);
                bit_matches("start_ready at tx_done", start_ready, 1'b1);
                len_matches("data_take count", len_t'(takes), take_q.pop_front());
                takes = 0;
                done_cnt++;
            end
            prev_en = gmii_tx_en;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n       <= 1'b0;
        start_valid <= 1'b0;
        byte_num    <= '0;
        des_mac     <= '0;
        des_ip      <= '0;
        board_mac   <= '0;
        board_ip    <= '0;
        data_word   <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        bit_matches("gmii_tx_en after reset", gmii_tx_en, 1'b0);
        bit_matches("tx_done after reset", tx_done, 1'b0);
        bit_matches("data_take after reset", data_take, 1'b0);
        bit_matches("start_ready after reset", start_ready, 1'b1);
        byte_matches("gmii_txd after reset", gmii_txd, 8'h00);
        while (done_cnt < N_FRAMES)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected bytes never appeared on gmii", exp_q.size());
        end
        $display("frames %0d, bytes checked %0d, errors %0d", done_cnt, checked, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/net_proto_pkg.sv
source/tx_ctrl_pkg.sv
source/frame_sequencer.sv
source/frame_header.sv
source/crc32_d8.sv
source/gmii_byte_mux.sv
source/udp_gmii_tx.sv
verif/udp_gmii_tx_asserts.sv
verif/tb_udp_gmii_tx.sv

// File: Makefile
TOP := tb_udp_gmii_tx
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
